// ==== gpioCore.f ====
+incdir+.
gpioPkg.sv
gpioApbControl.sv
gpioRegFile.sv
gpioInputSync.sv
gpioIrqDetect.sv
gpioReadMux.sv
gpioCore.sv
gpioCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the GPIO testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f gpioCore.f --top-module gpioCoreTb -o gpioCoreSim

./obj_dir/gpioCoreSim

// ==== gpioCoreTb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "gpioCore_settings.svh"

module gpioCoreTb;

  logic              PCLK;
  logic              arstN;
  gpioPkg::apbReq_t  apb;
  gpioPkg::pinVec_t  gpioIn;
  gpioPkg::apbData_t rdata;
  gpioPkg::pinVec_t  gpioOut;
  gpioPkg::pinVec_t  gpioOe;
  gpioPkg::pinVec_t  intVec;
  logic              intOr;

  // Shadow of the register state and the settled pin levels
  gpioPkg::pinCfg_t  shadowCfg [`GPIO_IO_NUM];
  gpioPkg::pinVec_t  shadowOut;
  gpioPkg::pinVec_t  pinsNow;
  gpioPkg::pinVec_t  edgeLatch;
  gpioPkg::pinVec_t  oldPins;
  gpioPkg::pinVec_t  mask;
  int unsigned       seed;

  gpioCore dut0
  (
    .PCLK    (PCLK),
    .arstN   (arstN),
    .apb     (apb),
    .gpioIn  (gpioIn),
    .rdata   (rdata),
    .gpioOut (gpioOut),
    .gpioOe  (gpioOe),
    .intVec  (intVec),
    .intOr   (intOr)
  );

  always #5 PCLK = ~PCLK;

  task automatic failRun(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkWord(input string name, input gpioPkg::apbData_t exp,
                           input gpioPkg::apbData_t act);
    if (act !== exp)
      failRun($sformatf("mismatch %s expected %h actual %h", name, exp, act));
  endtask

  task automatic checkPins(input string name, input gpioPkg::pinVec_t exp,
                           input gpioPkg::pinVec_t act);
    if (act !== exp)
      failRun($sformatf("mismatch %s expected %h actual %h", name, exp, act));
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act);
    if (act !== exp)
      failRun($sformatf("mismatch %s expected %b actual %b", name, exp, act));
  endtask

  function automatic gpioPkg::pinCfg_t randCfg();
    return gpioPkg::pinCfg_t'(8'($urandom()));
  endfunction

  function automatic gpioPkg::pinCfg_t levelCfg();
    gpioPkg::pinCfg_t c;
    c = randCfg();
    c.intType = ($urandom() % 2 == 0) ? gpioPkg::intHigh : gpioPkg::intLow;
    return c;
  endfunction

  function automatic gpioPkg::pinCfg_t edgeCfg();
    gpioPkg::pinCfg_t c;
    int unsigned      k;
    c = randCfg();
    k = $urandom() % 3;
    case (k)
      0: c.intType = gpioPkg::intRise;
      1: c.intType = gpioPkg::intFall;
      default: c.intType = gpioPkg::intBoth;
    endcase
    return c;
  endfunction

  function automatic gpioPkg::pinVec_t expectIrq();
    gpioPkg::pinVec_t v;
    v = '0;
    for (int i = 0; i < `GPIO_IO_NUM; i++)
    begin
      if (shadowCfg[i].intEn)
      begin
        case (shadowCfg[i].intType)
          gpioPkg::intHigh: v[i] = pinsNow[i];
          gpioPkg::intLow:  v[i] = ~pinsNow[i];
          gpioPkg::intRise, gpioPkg::intFall, gpioPkg::intBoth: v[i] = edgeLatch[i];
          default: v[i] = 1'b0;
        endcase
      end
    end
    return v;
  endfunction

  function automatic gpioPkg::apbData_t expectRead(input gpioPkg::apbAddr_t addr);
    gpioPkg::apbData_t d;
    gpioPkg::pinVec_t  inMask;
    int                idx;
    d = '0;
    inMask = '0;
    idx = int'(addr[6:2]);
    for (int i = 0; i < `GPIO_IO_NUM; i++)
      inMask[i] = shadowCfg[i].inEn;
    if (addr < `GPIO_CFG_LIMIT)
    begin
      if (idx < `GPIO_IO_NUM)
        d[7:0] = shadowCfg[idx];
    end
    else if (addr == `GPIO_IRQ_ADDR)
      d[`GPIO_IO_NUM-1:0] = expectIrq();
    else if (addr == `GPIO_IN_ADDR)
      d[`GPIO_IO_NUM-1:0] = pinsNow & inMask;
    else if (addr == `GPIO_OUT_ADDR)
      d[`GPIO_IO_NUM-1:0] = shadowOut;
    return d;
  endfunction

  function automatic gpioPkg::pinVec_t expectOut();
    gpioPkg::pinVec_t v;
    for (int i = 0; i < `GPIO_IO_NUM; i++)
      v[i] = shadowOut[i] & shadowCfg[i].outEn;
    return v;
  endfunction

  function automatic gpioPkg::pinVec_t expectOe();
    gpioPkg::pinVec_t v;
    for (int i = 0; i < `GPIO_IO_NUM; i++)
      v[i] = shadowCfg[i].outEn & shadowCfg[i].bufEn;
    return v;
  endfunction

  // Edge flags latch only for enabled pins of the matching kind
  function automatic void updateEdges(input gpioPkg::pinVec_t oldP,
                                      input gpioPkg::pinVec_t newP);
    for (int i = 0; i < `GPIO_IO_NUM; i++)
    begin
      if (shadowCfg[i].intEn)
      begin
        case (shadowCfg[i].intType)
          gpioPkg::intRise: if (!oldP[i] && newP[i]) edgeLatch[i] = 1'b1;
          gpioPkg::intFall: if (oldP[i] && !newP[i]) edgeLatch[i] = 1'b1;
          gpioPkg::intBoth: if (oldP[i] != newP[i]) edgeLatch[i] = 1'b1;
          default: ;
        endcase
      end
    end
  endfunction

  task automatic apbWrite(input gpioPkg::apbAddr_t addr, input gpioPkg::apbData_t data);
    gpioPkg::apbReq_t req;
    req = '0;
    req.sel = 1'b1;
    req.write = 1'b1;
    req.addr = addr;
    req.wdata = data;
    @(posedge PCLK);
    apb <= req;
    @(posedge PCLK);
    apb.enable <= 1'b1;
    @(posedge PCLK);
    apb <= '0;
  endtask

  task automatic apbRead(input gpioPkg::apbAddr_t addr, output gpioPkg::apbData_t data);
    gpioPkg::apbReq_t req;
    req = '0;
    req.sel = 1'b1;
    req.addr = addr;
    @(posedge PCLK);
    apb <= req;
    @(posedge PCLK);
    apb.enable <= 1'b1;
    @(negedge PCLK);
    data = rdata;
    @(posedge PCLK);
    apb <= '0;
  endtask

  task automatic checkRead(input string name, input gpioPkg::apbAddr_t addr);
    gpioPkg::apbData_t got;
    apbRead(addr, got);
    checkWord($sformatf("%s @%h", name, addr), expectRead(addr), got);
  endtask

  task automatic writeCfg(input int idx, input gpioPkg::pinCfg_t c);
    gpioPkg::apbData_t d;
    d = '0;
    d[7:0] = c;
    shadowCfg[idx] = c;
    apbWrite(gpioPkg::apbAddr_t'(idx * 4), d);
  endtask

  task automatic setPins(input gpioPkg::pinVec_t v);
    @(posedge PCLK);
    gpioIn <= v;
    updateEdges(pinsNow, v);
    pinsNow = v;
  endtask

  task automatic settle(input int n);
    for (int i = 0; i < n; i++)
      @(posedge PCLK);
  endtask

  task automatic checkOutputs(input string name);
    @(negedge PCLK);
    checkPins({name, " gpioOut"}, expectOut(), gpioOut);
    checkPins({name, " gpioOe"}, expectOe(), gpioOe);
  endtask

  task automatic waitIrq(input string name);
    int   cycles;
    logic hit;
    cycles = 0;
    hit = 1'b0;
    while (!hit && cycles < 16)
    begin
      @(negedge PCLK);
      hit = (intVec === expectIrq());
      cycles++;
    end
    if (!hit)
      failRun($sformatf("timed out waiting for the interrupt vector in %s", name));
    // Must hold once reached
    settle(4);
    @(negedge PCLK);
    checkPins({name, " intVec"}, expectIrq(), intVec);
    checkFlag({name, " intOr"}, |expectIrq(), intOr);
  endtask

  initial
  begin
    PCLK = 1'b0;
    arstN = 1'b0;
    apb = '0;
    gpioIn = '0;
    shadowOut = '0;
    pinsNow = '0;
    edgeLatch = '0;
    for (int i = 0; i < `GPIO_IO_NUM; i++)
      shadowCfg[i] = '0;
    seed = $urandom(32'h22b48e8b);
    settle(16);
    arstN <= 1'b1;

    @(negedge PCLK);
    checkPins("reset gpioOut", '0, gpioOut);
    checkPins("reset gpioOe", '0, gpioOe);
    checkPins("reset intVec", '0, intVec);
    checkFlag("reset intOr", 1'b0, intOr);
    for (int i = 0; i < `GPIO_IO_NUM; i++)
      checkRead("reset cfg", gpioPkg::apbAddr_t'(i * 4));

    for (int i = 0; i < `GPIO_IO_NUM; i++)
      writeCfg(i, randCfg());
    for (int i = 0; i < `GPIO_IO_NUM; i++)
      checkRead("cfg readback", gpioPkg::apbAddr_t'(i * 4));
    for (int a = 8'h84; a <= 8'hFC; a += 4)
      checkRead("upper map", gpioPkg::apbAddr_t'(a));

    for (int r = 0; r < 4; r++)
    begin
      for (int i = 0; i < `GPIO_IO_NUM; i++)
        writeCfg(i, randCfg());
      shadowOut = gpioPkg::pinVec_t'($urandom());
      apbWrite(`GPIO_OUT_ADDR, gpioPkg::apbData_t'(shadowOut));
      checkOutputs("pin drive");
      checkRead("output reg", `GPIO_OUT_ADDR);
    end

    for (int r = 0; r < 8; r++)
    begin
      setPins(gpioPkg::pinVec_t'($urandom()));
      settle(3);
      checkRead("input vector", `GPIO_IN_ADDR);
    end

    for (int i = 0; i < `GPIO_IO_NUM; i++)
      writeCfg(i, levelCfg());
    waitIrq("level config");
    for (int r = 0; r < 6; r++)
    begin
      setPins(gpioPkg::pinVec_t'($urandom()));
      waitIrq("level irq");
      checkRead("level status", `GPIO_IRQ_ADDR);
    end

    // Pins are quiet here, so no flag of the new kinds is set yet
    for (int i = 0; i < `GPIO_IO_NUM; i++)
      writeCfg(i, edgeCfg());
    edgeLatch = '0;
    waitIrq("edge config");
    for (int r = 0; r < 6; r++)
    begin
      oldPins = pinsNow;
      setPins(gpioPkg::pinVec_t'($urandom()));
      waitIrq("edge set");
      setPins(oldPins);
      waitIrq("edge return");
      checkRead("edge status", `GPIO_IRQ_ADDR);
      mask = gpioPkg::pinVec_t'($urandom());
      apbWrite(`GPIO_IRQ_ADDR, gpioPkg::apbData_t'(mask));
      edgeLatch &= ~mask;
      @(negedge PCLK);
      checkPins("edge clear intVec", expectIrq(), intVec);
      checkRead("edge clear status", `GPIO_IRQ_ADDR);
    end

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== gpioCore.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "gpioCore_settings.svh"

module gpioCore
(
  input  logic              PCLK,
  input  logic              arstN,
  input  gpioPkg::apbReq_t  apb,
  input  gpioPkg::pinVec_t  gpioIn,
  output gpioPkg::apbData_t rdata,
  output gpioPkg::pinVec_t  gpioOut,
  output gpioPkg::pinVec_t  gpioOe,
  output gpioPkg::pinVec_t  intVec,
  output logic              intOr
);

  gpioPkg::wrStrobe_t wr;
  gpioPkg::regSel_e   rdSel;
  logic [4:0]         rdIdx;
  gpioPkg::pinCfg_t   cfg [`GPIO_IO_NUM];
  gpioPkg::pinVec_t   outReg;
  gpioPkg::pinVec_t   syncIn;
  gpioPkg::pinVec_t   prevIn;

  gpioApbControl ctrl0
  (
    .PCLK  (PCLK),
    .arstN (arstN),
    .apb   (apb),
    .wr    (wr),
    .rdSel (rdSel),
    .rdIdx (rdIdx)
  );

  gpioRegFile regFile0
  (
    .PCLK    (PCLK),
    .arstN   (arstN),
    .wr      (wr),
    .cfg     (cfg),
    .outReg  (outReg),
    .gpioOut (gpioOut),
    .gpioOe  (gpioOe)
  );

  gpioInputSync inSync0
  (
    .PCLK   (PCLK),
    .arstN  (arstN),
    .gpioIn (gpioIn),
    .syncIn (syncIn),
    .prevIn (prevIn)
  );

  gpioIrqDetect irq0
  (
    .PCLK   (PCLK),
    .arstN  (arstN),
    .cfg    (cfg),
    .syncIn (syncIn),
    .prevIn (prevIn),
    .wr     (wr),
    .intVec (intVec),
    .intOr  (intOr)
  );

  // Zero wait state read path
  gpioReadMux readMux0
  (
    .rdSel  (rdSel),
    .rdIdx  (rdIdx),
    .cfg    (cfg),
    .intVec (intVec),
    .syncIn (syncIn),
    .outReg (outReg),
    .rdata  (rdata)
  );

endmodule

`default_nettype wire

// ==== gpioReadMux.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "gpioCore_settings.svh"

module gpioReadMux
(
  input  gpioPkg::regSel_e  rdSel,
  input  logic [4:0]        rdIdx,
  input  gpioPkg::pinCfg_t  cfg [`GPIO_IO_NUM],
  input  gpioPkg::pinVec_t  intVec,
  input  gpioPkg::pinVec_t  syncIn,
  input  gpioPkg::pinVec_t  outReg,
  output gpioPkg::apbData_t rdata
);

  gpioPkg::pinVec_t inMask;

  always_comb
  begin
    inMask = '0;
    for (int i = 0; i < `GPIO_IO_NUM; i++)
      inMask[i] = cfg[i].inEn;
  end

  always_comb
  begin
    rdata = '0;
    case (rdSel)
      gpioPkg::selCfg:
      begin
        // Indices past the last pin read as zero
        if (rdIdx < `GPIO_IO_NUM)
          rdata[7:0] = cfg[rdIdx];
      end
      gpioPkg::selIrq: rdata[`GPIO_IO_NUM-1:0] = intVec;
      gpioPkg::selIn:  rdata[`GPIO_IO_NUM-1:0] = syncIn & inMask;
      gpioPkg::selOut: rdata[`GPIO_IO_NUM-1:0] = outReg;
      default:         rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== gpioIrqDetect.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "gpioCore_settings.svh"

module gpioIrqDetect
(
  input  logic               PCLK,
  input  logic               arstN,
  input  gpioPkg::pinCfg_t   cfg [`GPIO_IO_NUM],
  input  gpioPkg::pinVec_t   syncIn,
  input  gpioPkg::pinVec_t   prevIn,
  input  gpioPkg::wrStrobe_t wr,
  output gpioPkg::pinVec_t   intVec,
  output logic               intOr
);

  for (genvar i = 0; i < `GPIO_IO_NUM; i++)
  begin : genPin
    // Bit 0 rise, bit 1 fall, bit 2 both edges
    logic [2:0] edgeEvt;
    logic [2:0] edgeHit;
    logic [2:0] edgeFlag;
    logic       edgeClr;
    logic       pinSrc;

    assign edgeEvt[0] = syncIn[i] & ~prevIn[i];
    assign edgeEvt[1] = ~syncIn[i] & prevIn[i];
    assign edgeEvt[2] = syncIn[i] ^ prevIn[i];

    assign edgeHit[0] = cfg[i].intEn && (cfg[i].intType == gpioPkg::intRise);
    assign edgeHit[1] = cfg[i].intEn && (cfg[i].intType == gpioPkg::intFall);
    assign edgeHit[2] = cfg[i].intEn && (cfg[i].intType == gpioPkg::intBoth);

    assign edgeClr = wr.irqClr && wr.wdata[i];

    // A new event beats a clear in the same cycle
    always_ff @(posedge PCLK or negedge arstN)
    begin
      if (!arstN)
        edgeFlag <= '0;
      else
      begin
        for (int k = 0; k < 3; k++)
        begin
          if (!edgeHit[k])
            edgeFlag[k] <= 1'b0;
          else if (edgeEvt[k])
            edgeFlag[k] <= 1'b1;
          else if (edgeClr)
            edgeFlag[k] <= 1'b0;
        end
      end
    end

    always_comb
    begin
      case (cfg[i].intType)
        gpioPkg::intHigh: pinSrc = syncIn[i];
        gpioPkg::intLow:  pinSrc = ~syncIn[i];
        gpioPkg::intRise: pinSrc = edgeFlag[0];
        gpioPkg::intFall: pinSrc = edgeFlag[1];
        gpioPkg::intBoth: pinSrc = edgeFlag[2];
        default:          pinSrc = 1'b0;
      endcase
    end

    assign intVec[i] = cfg[i].intEn & pinSrc;
  end

  assign intOr = |intVec;

endmodule

`default_nettype wire

// ==== gpioInputSync.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "gpioCore_settings.svh"

module gpioInputSync
(
  input  logic             PCLK,
  input  logic             arstN,
  input  gpioPkg::pinVec_t gpioIn,
  output gpioPkg::pinVec_t syncIn,
  output gpioPkg::pinVec_t prevIn
);

  gpioPkg::pinVec_t metaIn;

  // Two flops for metastability, a third holds the last value for edges
  always_ff @(posedge PCLK or negedge arstN)
  begin
    if (!arstN)
    begin
      metaIn <= '0;
      syncIn <= '0;
      prevIn <= '0;
    end
    else
    begin
      metaIn <= gpioIn;
      syncIn <= metaIn;
      prevIn <= syncIn;
    end
  end

endmodule

`default_nettype wire

// ==== gpioRegFile.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "gpioCore_settings.svh"

module gpioRegFile
(
  input  logic               PCLK,
  input  logic               arstN,
  input  gpioPkg::wrStrobe_t wr,
  output gpioPkg::pinCfg_t   cfg [`GPIO_IO_NUM],
  output gpioPkg::pinVec_t   outReg,
  output gpioPkg::pinVec_t   gpioOut,
  output gpioPkg::pinVec_t   gpioOe
);

  // One configuration byte per pin, word aligned
  for (genvar i = 0; i < `GPIO_IO_NUM; i++)
  begin : genCfg
    always_ff @(posedge PCLK or negedge arstN)
    begin
      if (!arstN)
        cfg[i] <= '0;
      else if (wr.cfgWr && (wr.cfgIdx == 5'(i)))
        cfg[i] <= gpioPkg::pinCfg_t'(wr.wdata[7:0]);
    end
  end

  always_ff @(posedge PCLK or negedge arstN)
  begin
    if (!arstN)
      outReg <= '0;
    else if (wr.outWr)
      outReg <= wr.wdata[`GPIO_IO_NUM-1:0];
  end

  // Pin drive gated by the per-pin enables
  always_comb
  begin
    gpioOut = '0;
    gpioOe = '0;
    for (int i = 0; i < `GPIO_IO_NUM; i++)
    begin
      gpioOut[i] = outReg[i] & cfg[i].outEn;
      gpioOe[i] = cfg[i].outEn & cfg[i].bufEn;
    end
  end

endmodule

`default_nettype wire

// ==== gpioApbControl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "gpioCore_settings.svh"

module gpioApbControl
(
  input  logic               PCLK,
  input  logic               arstN,
  input  gpioPkg::apbReq_t   apb,
  output gpioPkg::wrStrobe_t wr,
  output gpioPkg::regSel_e   rdSel,
  output logic [4:0]         rdIdx
);

  typedef enum logic
  {
    phIdle,
    phSetup
  } apbPhase_e;

  apbPhase_e phase;
  logic      wrEn;
  logic      inCfg;

  // Tracks whether the last cycle was a setup phase
  always_ff @(posedge PCLK or negedge arstN)
  begin
    if (!arstN)
      phase <= phIdle;
    else if (apb.sel && !apb.enable)
      phase <= phSetup;
    else
      phase <= phIdle;
  end

  // One write per transfer, in the access phase only
  assign wrEn = apb.sel && apb.enable && apb.write && (phase == phSetup);
  assign inCfg = (apb.addr < `GPIO_CFG_LIMIT);

  always_comb
  begin
    wr.cfgWr = wrEn && inCfg;
    wr.cfgIdx = apb.addr[6:2];
    wr.irqClr = wrEn && (apb.addr == `GPIO_IRQ_ADDR);
    wr.outWr = wrEn && (apb.addr == `GPIO_OUT_ADDR);
    wr.wdata = apb.wdata;
  end

  always_comb
  begin
    if (inCfg)
      rdSel = gpioPkg::selCfg;
    else if (apb.addr == `GPIO_IRQ_ADDR)
      rdSel = gpioPkg::selIrq;
    else if (apb.addr == `GPIO_IN_ADDR)
      rdSel = gpioPkg::selIn;
    else if (apb.addr == `GPIO_OUT_ADDR)
      rdSel = gpioPkg::selOut;
    else
      rdSel = gpioPkg::selNone;
  end

  assign rdIdx = apb.addr[6:2];

endmodule

`default_nettype wire

// ==== gpioPkg.sv ====
`default_nettype none

`include "gpioCore_settings.svh"

package gpioPkg;

  // Interrupt kind per pin, codes 5 to 7 never fire
  typedef enum logic [2:0]
  {
    intHigh = 3'd0,
    intLow = 3'd1,
    intRise = 3'd2,
    intFall = 3'd3,
    intBoth = 3'd4
  } intType_e;

  typedef struct packed
  {
    intType_e intType;
    logic spare;
    logic intEn;
    logic bufEn;
    logic inEn;
    logic outEn;
  } pinCfg_t;

  typedef logic [`GPIO_IO_NUM-1:0] pinVec_t;
  typedef logic [`GPIO_APB_WIDTH-1:0] apbData_t;
  typedef logic [`GPIO_ADDR_WIDTH-1:0] apbAddr_t;

  typedef struct packed
  {
    logic sel;
    logic enable;
    logic write;
    apbAddr_t addr;
    apbData_t wdata;
  } apbReq_t;

  typedef enum logic [2:0]
  {
    selCfg,
    selIrq,
    selIn,
    selOut,
    selNone
  } regSel_e;

  typedef struct packed
  {
    logic cfgWr;
    logic [4:0] cfgIdx;
    logic irqClr;
    logic outWr;
    apbData_t wdata;
  } wrStrobe_t;

endpackage

`default_nettype wire

// ==== gpioCore_settings.svh ====
`ifndef GPIO_CORE_SETTINGS_SVH
`define GPIO_CORE_SETTINGS_SVH

// Number of GPIO pins, at most 32
`define GPIO_IO_NUM 32

`define GPIO_APB_WIDTH 32
`define GPIO_ADDR_WIDTH 8

// Register map
`define GPIO_CFG_LIMIT 8'h80
`define GPIO_IRQ_ADDR 8'h80
`define GPIO_IN_ADDR 8'h90
`define GPIO_OUT_ADDR 8'hA0

`endif
